// ==== include/csr_consts.svh ====
// CSR unit constants
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Machine word width, RV32 only
`define CSR_XLEN 32

// Trap base after reset
// Word aligned, direct mode
`define CSR_MTVEC_RESET 32'h0000_0100

// misa for RV32I
// MXL = 1 in bits 31:30
// Extension bit 8 is I, nothing else
`define CSR_MISA_VALUE 32'h4000_0100

`endif

// ==== source/secv_pkg.sv ====
// SEC-V core types
`include "csr_consts.svh"

package secv_pkg;

    // Operands from execute stage
    typedef struct packed {
        logic                 ena;  // One cycle per instruction
        logic [`CSR_XLEN-1:0] src1; // rs1 value or zero-extended uimm
        logic [`CSR_XLEN-1:0] src2; // CSR address in bits 11:0
    } funit_in_t;

    // Result back to execute stage
    typedef struct packed {
        logic                 rdy;  // Result valid
        logic                 err;  // Illegal instruction
        logic [`CSR_XLEN-1:0] res;  // Old CSR value
    } funit_out_t;

    // Zicsr funct3 encodings
    typedef enum logic [2:0] {
        FUNCT3_CSR_RW  = 3'b001,
        FUNCT3_CSR_RS  = 3'b010,
        FUNCT3_CSR_RC  = 3'b011,
        FUNCT3_CSR_RWI = 3'b101, // Immediate forms
        FUNCT3_CSR_RSI = 3'b110,
        FUNCT3_CSR_RCI = 3'b111
    } funct3_csr_t;

    // Synchronous exception codes, mcause low bits
    typedef enum logic [3:0] {
        EX_CAUSE_INSTR_MISALIGNED = 4'd0,
        EX_CAUSE_ILLEGAL_INSTR    = 4'd2,
        EX_CAUSE_BREAKPOINT       = 4'd3,
        EX_CAUSE_LOAD_MISALIGNED  = 4'd4,
        EX_CAUSE_STORE_MISALIGNED = 4'd6,
        EX_CAUSE_ECALL_M          = 4'd11 // Only M-mode exists
    } ex_cause_t;

    // 4'd1, 4'd5 and 4'd7 are access faults
    // No PMP or bus error path, so never raised

endpackage

// ==== source/csr_pkg.sv ====
// Machine CSR types
`include "csr_consts.svh"

package csr_pkg;

    // Implemented machine CSR addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_MHARTID  = 12'hF14  // Read-only space
    } csr_adr_t;

    // mstatus word, only M-mode fields
    typedef struct packed {
        logic [`CSR_XLEN-1:13] rsvd3;
        logic [1:0]            mpp;   // Always 11
        logic [2:0]            rsvd2;
        logic                  mpie;  // Bit 7
        logic [2:0]            rsvd1;
        logic                  mie;   // Bit 3
        logic [2:0]            rsvd0;
    } mstatus_t;

    // One bit per machine interrupt source
    // Placed at 11, 7 and 3 in mip/mie
    typedef struct packed {
        logic mei; // External
        logic mti; // Timer
        logic msi; // Software
    } ivec_t;

    // Interrupt codes, mcause low bits
    typedef enum logic [3:0] {
        INTR_CAUSE_SW    = 4'd3,
        INTR_CAUSE_TIMER = 4'd7,
        INTR_CAUSE_EXT   = 4'd11
    } intr_cause_t;

    // mcause, same word read two ways by the flag
    typedef union packed {
        struct packed {
            logic                  flag; // Clear for exceptions
            logic [`CSR_XLEN-6:0]  rsvd;
            secv_pkg::ex_cause_t   code;
        } exc;
        struct packed {
            logic                  flag; // Set for interrupts
            logic [`CSR_XLEN-6:0]  rsvd;
            intr_cause_t           code;
        } irq;
    } mcause_u;

endpackage

// ==== source/csr_intr.sv ====
// Machine interrupt controller
`timescale 1ns/1ps

module csr_intr #(
    parameter int SYNC_STAGES = 2   // At least two
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    input  csr_pkg::ivec_t       irq_i,      // Asynchronous lines
    input  csr_pkg::ivec_t       ena_vec_i,  // mie bits
    input  logic                 glb_ena_i,  // mstatus.MIE

    output csr_pkg::ivec_t       pend_o,     // mip bits
    output logic                 req_o,      // To pipeline, held until taken
    output csr_pkg::intr_cause_t cause_o     // Winning source
);
    // Stage 0 samples the lines, last stage is safe to use
    csr_pkg::ivec_t [SYNC_STAGES-1:0] sync_q;
    csr_pkg::ivec_t                   act;   // Pending and enabled

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], irq_i}; // Shift toward MSB
        end
    end

    assign pend_o = sync_q[SYNC_STAGES-1];
    assign act    = pend_o & ena_vec_i;
    assign req_o  = glb_ena_i && (|act);  // Drops once trap entry clears MIE

    // Fixed priority, external > software > timer
    always_comb begin
        if (act.mei) begin
            cause_o = csr_pkg::INTR_CAUSE_EXT;
        end else if (act.msi) begin
            cause_o = csr_pkg::INTR_CAUSE_SW;
        end else begin
            cause_o = csr_pkg::INTR_CAUSE_TIMER; // Also idle value
        end
    end

    // Cause must point at an active source
    a_cause_active: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req_o |-> ((cause_o == csr_pkg::INTR_CAUSE_EXT)   && act.mei) ||
                  ((cause_o == csr_pkg::INTR_CAUSE_SW)    && act.msi) ||
                  ((cause_o == csr_pkg::INTR_CAUSE_TIMER) && act.mti))
        else $error("csr_intr: cause %0d not pending and enabled", cause_o);

endmodule

// ==== source/csr_regs.sv ====
// Machine CSR register file
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_regs (
    input  logic                 clk_i,
    input  logic                 arst_n_i,

    // CSR access
    input  logic [11:0]          csr_adr_i,
    input  logic                 csr_we_i,       // Write intent
    input  logic [`CSR_XLEN-1:0] csr_dat_i,
    output logic [`CSR_XLEN-1:0] csr_dat_o,
    output logic                 csr_illegal_o,

    // Traps
    input  logic [`CSR_XLEN-1:0] trap_pc_i,
    input  logic [`CSR_XLEN-1:0] trap_adr_i,
    output logic [`CSR_XLEN-1:0] trap_vec_o,
    input  logic                 mret_i,
    input  logic                 ex_i,
    input  secv_pkg::ex_cause_t  ex_cause_i,

    // Interrupts
    input  logic                 intr_take_i,    // First ack cycle
    input  csr_pkg::intr_cause_t intr_cause_i,
    input  csr_pkg::ivec_t       intr_pend_i,
    output logic                 intr_glb_ena_o,
    output csr_pkg::ivec_t       intr_ena_vec_o
);
    logic                 mst_mie_q, mst_mpie_q;  // mstatus state bits
    csr_pkg::ivec_t       mie_q;
    logic [`CSR_XLEN-1:0] mtvec_q, mscratch_q, mepc_q, mtval_q;
    csr_pkg::mcause_u     mcause_q;

    csr_pkg::mstatus_t    mstatus_rd, mstatus_wr;
    csr_pkg::mcause_u     trap_cause;
    logic                 adr_known, ro_space, wr_en, trap_take;

    // Interrupt bits to their mip/mie positions
    function automatic logic [`CSR_XLEN-1:0] ivec_word(csr_pkg::ivec_t v);
        logic [`CSR_XLEN-1:0] w;
        w     = '0;
        w[3]  = v.msi;
        w[7]  = v.mti;
        w[11] = v.mei;
        return w;
    endfunction

    // Read mux
    always_comb begin
        mstatus_rd      = '0;
        mstatus_rd.mpp  = 2'b11;      // Hardwired machine mode
        mstatus_rd.mpie = mst_mpie_q;
        mstatus_rd.mie  = mst_mie_q;
        adr_known       = 1'b1;
        csr_dat_o       = '0;
        case (csr_adr_i)
            csr_pkg::CSR_MSTATUS:  csr_dat_o = mstatus_rd;
            csr_pkg::CSR_MISA:     csr_dat_o = `CSR_MISA_VALUE;
            csr_pkg::CSR_MIE:      csr_dat_o = ivec_word(mie_q);
            csr_pkg::CSR_MTVEC:    csr_dat_o = mtvec_q;
            csr_pkg::CSR_MSCRATCH: csr_dat_o = mscratch_q;
            csr_pkg::CSR_MEPC:     csr_dat_o = mepc_q;
            csr_pkg::CSR_MCAUSE:   csr_dat_o = mcause_q;
            csr_pkg::CSR_MTVAL:    csr_dat_o = mtval_q;
            csr_pkg::CSR_MIP:      csr_dat_o = ivec_word(intr_pend_i); // Live lines
            csr_pkg::CSR_MHARTID:  csr_dat_o = '0;                     // Single hart
            default:               adr_known = 1'b0;
        endcase
    end

    // misa is fixed in this core, so treat it like read-only space
    assign ro_space      = (csr_adr_i[11:10] == 2'b11) || (csr_adr_i == csr_pkg::CSR_MISA);
    assign csr_illegal_o = !adr_known || (csr_we_i && ro_space);
    assign wr_en         = csr_we_i && !csr_illegal_o;  // Illegal writes dropped here
    assign mstatus_wr    = csr_dat_i;

    // Trap cause word, view picked by source
    assign trap_take = ex_i || intr_take_i;
    always_comb begin
        trap_cause = '0;
        if (ex_i) begin
            trap_cause.exc.flag = 1'b0;
            trap_cause.exc.code = ex_cause_i;
        end else begin
            trap_cause.irq.flag = 1'b1;
            trap_cause.irq.code = intr_cause_i;
        end
    end

    // Priority: trap entry, then mret, then CSR write
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mst_mie_q  <= 1'b0;
            mst_mpie_q <= 1'b0;
            mie_q      <= '0;
            mtvec_q    <= `CSR_MTVEC_RESET;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
        end else if (trap_take) begin
            mepc_q     <= trap_pc_i;
            mtval_q    <= ex_i ? trap_adr_i : '0;  // No value for interrupts
            mcause_q   <= trap_cause;
            mst_mpie_q <= mst_mie_q;               // Stack enable
            mst_mie_q  <= 1'b0;
        end else if (mret_i) begin
            mst_mie_q  <= mst_mpie_q;
            mst_mpie_q <= 1'b1;
        end else if (wr_en) begin
            case (csr_adr_i)
                csr_pkg::CSR_MSTATUS: begin
                    mst_mie_q  <= mstatus_wr.mie;
                    mst_mpie_q <= mstatus_wr.mpie;
                end
                csr_pkg::CSR_MIE: begin
                    mie_q.msi <= csr_dat_i[3];
                    mie_q.mti <= csr_dat_i[7];
                    mie_q.mei <= csr_dat_i[11];
                end
                csr_pkg::CSR_MTVEC:    mtvec_q    <= csr_dat_i;
                csr_pkg::CSR_MSCRATCH: mscratch_q <= csr_dat_i;
                csr_pkg::CSR_MEPC:     mepc_q     <= csr_dat_i;
                csr_pkg::CSR_MCAUSE:   mcause_q   <= csr_dat_i;
                csr_pkg::CSR_MTVAL:    mtval_q    <= csr_dat_i;
                default: ;             // mip has no writable bits
            endcase
        end
    end

    // Direct mode only, mode bits never reach fetch
    assign trap_vec_o     = mret_i ? mepc_q : {mtvec_q[`CSR_XLEN-1:2], 2'b00};
    assign intr_glb_ena_o = mst_mie_q;
    assign intr_ena_vec_o = mie_q;

    // Pipeline serializes exceptions and interrupt acceptance
    a_trap_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ex_i && intr_take_i))
        else $error("csr_regs: exception and interrupt entry in same cycle");

endmodule

// ==== source/csr.sv ====
// CSR function unit
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr (
    input  logic                   clk_i,
    input  logic                   arst_n_i,

    // Function unit exchange
    input  secv_pkg::funit_in_t    fu_i,
    output secv_pkg::funit_out_t   fu_o,
    input  secv_pkg::funct3_csr_t  funct_i,
    input  logic                   rs1_zero_i,   // rs1 is x0 or uimm is 0

    // Traps
    input  logic [`CSR_XLEN-1:0]   trap_pc_i,
    input  logic [`CSR_XLEN-1:0]   trap_adr_i,
    input  logic                   mret_i,
    input  logic                   ex_i,
    input  secv_pkg::ex_cause_t    ex_cause_i,
    output logic [`CSR_XLEN-1:0]   trap_vec_o,

    // Interrupts
    input  csr_pkg::ivec_t         irq_i,
    output logic                   intr_req_o,
    input  logic                   intr_ack_i
);
    logic [`CSR_XLEN-1:0] csr_rdat, csr_wdat;
    logic                 csr_we, csr_illegal, funct_err;
    logic                 ack_q, intr_take;

    csr_pkg::intr_cause_t intr_cause;
    csr_pkg::ivec_t       intr_pend, intr_ena_vec;
    logic                 intr_glb_ena;

    csr_regs u_regs (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .csr_adr_i      (fu_i.src2[11:0]),
        .csr_we_i       (csr_we),
        .csr_dat_i      (csr_wdat),
        .csr_dat_o      (csr_rdat),
        .csr_illegal_o  (csr_illegal),
        .trap_pc_i      (trap_pc_i),
        .trap_adr_i     (trap_adr_i),
        .trap_vec_o     (trap_vec_o),
        .mret_i         (mret_i),
        .ex_i           (ex_i),
        .ex_cause_i     (ex_cause_i),
        .intr_take_i    (intr_take),
        .intr_cause_i   (intr_cause),
        .intr_pend_i    (intr_pend),
        .intr_glb_ena_o (intr_glb_ena),
        .intr_ena_vec_o (intr_ena_vec)
    );

    csr_intr #(
        .SYNC_STAGES (2)
    ) u_intr (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .irq_i     (irq_i),
        .ena_vec_i (intr_ena_vec),
        .glb_ena_i (intr_glb_ena),
        .pend_o    (intr_pend),
        .req_o     (intr_req_o),
        .cause_o   (intr_cause)
    );

    // Read-modify-write, result always the old value
    always_comb begin
        fu_o      = '0;
        csr_we    = 1'b0;
        csr_wdat  = '0;
        funct_err = 1'b0;
        if (fu_i.ena) begin
            fu_o.rdy = 1'b1;          // No back-pressure
            fu_o.res = csr_rdat;
            case (funct_i)
                secv_pkg::FUNCT3_CSR_RW, secv_pkg::FUNCT3_CSR_RWI: begin
                    csr_wdat = fu_i.src1;
                    csr_we   = 1'b1;  // Always writes
                end
                secv_pkg::FUNCT3_CSR_RS, secv_pkg::FUNCT3_CSR_RSI: begin
                    csr_wdat = csr_rdat | fu_i.src1;
                    csr_we   = !rs1_zero_i; // Pure read with x0
                end
                secv_pkg::FUNCT3_CSR_RC, secv_pkg::FUNCT3_CSR_RCI: begin
                    csr_wdat = csr_rdat & ~fu_i.src1;
                    csr_we   = !rs1_zero_i;
                end
                default: funct_err = 1'b1; // No write issued
            endcase
            fu_o.err = funct_err || csr_illegal;
        end
    end

    // Ack edge detect, one take pulse per handshake
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= intr_ack_i;
        end
    end
    assign intr_take = intr_ack_i && !ack_q;

    // A held ena would repeat the write
    a_ena_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fu_i.ena |=> !fu_i.ena)
        else $error("csr: fu_i.ena held for two cycles");

endmodule

// ==== source/csr_unit_top.sv ====
// CSR unit top level
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  secv_pkg::funit_in_t    fu_i,
    output secv_pkg::funit_out_t   fu_o,
    input  secv_pkg::funct3_csr_t  funct_i,
    input  logic                   rs1_zero_i,
    input  logic [`CSR_XLEN-1:0]   trap_pc_i,
    input  logic [`CSR_XLEN-1:0]   trap_adr_i,
    input  logic                   mret_i,
    input  logic                   ex_i,
    input  secv_pkg::ex_cause_t    ex_cause_i,
    output logic [`CSR_XLEN-1:0]   trap_vec_o,    // To fetch
    input  csr_pkg::ivec_t         irq_i,         // Raw interrupt lines
    output logic                   intr_req_o,
    input  logic                   intr_ack_i
);
    csr u_csr (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .fu_i       (fu_i),
        .fu_o       (fu_o),
        .funct_i    (funct_i),
        .rs1_zero_i (rs1_zero_i),
        .trap_pc_i  (trap_pc_i),
        .trap_adr_i (trap_adr_i),
        .mret_i     (mret_i),
        .ex_i       (ex_i),
        .ex_cause_i (ex_cause_i),
        .trap_vec_o (trap_vec_o),
        .irq_i      (irq_i),
        .intr_req_o (intr_req_o),
        .intr_ack_i (intr_ack_i)
    );

endmodule

// ==== tb/csr_tb.sv ====
// CSR unit testbench
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_tb;
    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 10;
    localparam int N_RAND      = 40;   // Random ops in test 2
    localparam int REQ_TIMEOUT = 20;   // Cycles to wait for intr_req_o
    // Each op takes 2 cycles, about 60 directed ops, 4 request waits
    localparam int RUN_CYCLES  = RST_CYCLES + (N_RAND + 60) * 2 + 4 * REQ_TIMEOUT + 60;

    logic                  clk = 1'b0;
    logic                  arst_n = 1'b0;
    secv_pkg::funit_in_t   fu;
    secv_pkg::funit_out_t  fu_o;
    secv_pkg::funct3_csr_t funct;
    secv_pkg::ex_cause_t   ex_cause;
    csr_pkg::ivec_t        irq;
    logic                  rs1_zero, mret, ex, intr_ack, intr_req;
    logic [`CSR_XLEN-1:0]  trap_pc, trap_adr, trap_vec;
    logic [`CSR_XLEN-1:0]  exp_res, exp_vec;
    logic                  exp_err;
    logic                  req_quiet = 1'b0;  // intr_req_o must stay low

    // Shadow copies of the CSRs
    logic                  sh_mie_st = 1'b0;  // mstatus.MIE
    logic                  sh_mpie = 1'b0;
    logic [`CSR_XLEN-1:0]  sh_mie = '0;
    logic [`CSR_XLEN-1:0]  sh_mtvec = `CSR_MTVEC_RESET;
    logic [`CSR_XLEN-1:0]  sh_mscratch = '0;
    logic [`CSR_XLEN-1:0]  sh_mepc = '0;
    logic [`CSR_XLEN-1:0]  sh_mcause = '0;
    logic [`CSR_XLEN-1:0]  sh_mtval = '0;

    int errors = 0;
    int err_mark = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    logic [3:0] ex_codes [6] = '{4'd0, 4'd2, 4'd3, 4'd4, 4'd6, 4'd11};
    logic [2:0] funct_codes [6] = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};

    csr_unit_top u_csr_unit_top (
        .clk_i (clk), .arst_n_i (arst_n), .fu_i (fu), .fu_o (fu_o),
        .funct_i (funct), .rs1_zero_i (rs1_zero), .trap_pc_i (trap_pc),
        .trap_adr_i (trap_adr), .mret_i (mret), .ex_i (ex), .ex_cause_i (ex_cause),
        .trap_vec_o (trap_vec), .irq_i (irq), .intr_req_o (intr_req),
        .intr_ack_i (intr_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign exp_vec = mret ? sh_mepc : {sh_mtvec[`CSR_XLEN-1:2], 2'b00};  // Fetch target

    a_rdy: assert property (@(posedge clk) disable iff (!arst_n) fu.ena |-> fu_o.rdy)
        else begin
            errors++;
            $display("error fu_o.rdy: got %h expected 1", $sampled(fu_o.rdy));
        end
    a_res: assert property (@(posedge clk) disable iff (!arst_n) fu.ena |-> fu_o.res == exp_res)
        else begin
            errors++;
            $display("error fu_o.res: got %h expected %h", $sampled(fu_o.res), $sampled(exp_res));
        end
    a_err: assert property (@(posedge clk) disable iff (!arst_n) fu.ena |-> fu_o.err == exp_err)
        else begin
            errors++;
            $display("error fu_o.err: got %h expected %h", $sampled(fu_o.err), $sampled(exp_err));
        end
    a_vec: assert property (@(posedge clk) disable iff (!arst_n) trap_vec == exp_vec)
        else begin
            errors++;
            $display("error trap_vec_o: got %h expected %h", $sampled(trap_vec), $sampled(exp_vec));
        end
    a_quiet: assert property (@(posedge clk) disable iff (!arst_n) req_quiet |-> !intr_req)
        else begin
            errors++;
            $display("error intr_req_o: got %h expected 0", $sampled(intr_req));
        end
    // Trap entry clears MIE, so req drops right after ack
    a_ack_drop: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(intr_ack) |=> !intr_req)
        else begin
            errors++;
            $display("error intr_req_o: got %h expected 0 after ack", $sampled(intr_req));
        end

    function automatic logic [`CSR_XLEN-1:0] irq_word(csr_pkg::ivec_t v);
        return {20'h0, v.mei, 3'b0, v.mti, 3'b0, v.msi, 3'b0};  // Bits 11, 7, 3
    endfunction

    function automatic logic [`CSR_XLEN-1:0] model_read(logic [11:0] adr);
        case (adr)
            csr_pkg::CSR_MSTATUS:  return {19'h0, 2'b11, 3'b0, sh_mpie, 3'b0, sh_mie_st, 3'b0};
            csr_pkg::CSR_MISA:     return `CSR_MISA_VALUE;
            csr_pkg::CSR_MIE:      return sh_mie;
            csr_pkg::CSR_MTVEC:    return sh_mtvec;
            csr_pkg::CSR_MSCRATCH: return sh_mscratch;
            csr_pkg::CSR_MEPC:     return sh_mepc;
            csr_pkg::CSR_MCAUSE:   return sh_mcause;
            csr_pkg::CSR_MTVAL:    return sh_mtval;
            csr_pkg::CSR_MIP:      return irq_word(irq);  // Lines held long enough to sync
            default:               return '0;             // mhartid and unknown
        endcase
    endfunction

    function automatic logic known_adr(logic [11:0] adr);
        return adr inside {csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MISA, csr_pkg::CSR_MIE,
                           csr_pkg::CSR_MTVEC, csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC,
                           csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL, csr_pkg::CSR_MIP,
                           csr_pkg::CSR_MHARTID};
    endfunction

    task automatic model_write(input logic [11:0] adr, input logic [`CSR_XLEN-1:0] v);
        case (adr)
            csr_pkg::CSR_MSTATUS: begin
                sh_mie_st = v[3];
                sh_mpie   = v[7];
            end
            csr_pkg::CSR_MIE:      sh_mie      = v & 32'h888;
            csr_pkg::CSR_MTVEC:    sh_mtvec    = v;
            csr_pkg::CSR_MSCRATCH: sh_mscratch = v;
            csr_pkg::CSR_MEPC:     sh_mepc     = v;
            csr_pkg::CSR_MCAUSE:   sh_mcause   = v;
            csr_pkg::CSR_MTVAL:    sh_mtval    = v;
            default: ;
        endcase
    endtask

    // One CSR instruction, then an idle cycle
    task automatic csr_op(input logic [2:0] f, input logic [11:0] adr,
                          input logic [`CSR_XLEN-1:0] src, input logic rz);
        logic [`CSR_XLEN-1:0] old_v;
        logic [`CSR_XLEN-1:0] new_v;
        logic                 wr;
        logic                 bad;
        old_v = model_read(adr);
        wr    = (f[1:0] == 2'b01) || ((f[1:0] != 2'b00) && !rz);
        case (f[1:0])
            2'b01:   new_v = src;
            2'b10:   new_v = old_v | src;
            default: new_v = old_v & ~src;
        endcase
        bad = (f[1:0] == 2'b00) || !known_adr(adr) ||
              (wr && (adr[11:10] == 2'b11 || adr == csr_pkg::CSR_MISA));
        fu.ena   <= 1'b1;
        fu.src1  <= src;
        fu.src2  <= {20'h0, adr};
        funct    <= secv_pkg::funct3_csr_t'(f);
        rs1_zero <= rz;
        exp_res  <= old_v;
        exp_err  <= bad;
        @(posedge clk);
        fu.ena <= 1'b0;
        if (wr && !bad) model_write(adr, new_v);  // Commits on this edge
        @(posedge clk);
    endtask

    task automatic take_exception();
        logic [3:0]           code;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] adr;
        code = ex_codes[$urandom_range(5)];
        pc   = $urandom & ~32'h3;
        adr  = $urandom;
        ex       <= 1'b1;
        ex_cause <= secv_pkg::ex_cause_t'(code);
        trap_pc  <= pc;
        trap_adr <= adr;
        @(posedge clk);
        ex        <= 1'b0;
        sh_mepc   = pc;
        sh_mtval  = adr;
        sh_mcause = {1'b0, 27'h0, code};  // Exception view
        sh_mpie   = sh_mie_st;
        sh_mie_st = 1'b0;
        @(posedge clk);
    endtask

    task automatic return_mret();
        mret <= 1'b1;
        @(posedge clk);
        mret      <= 1'b0;
        sh_mie_st = sh_mpie;
        sh_mpie   = 1'b1;
        @(posedge clk);
    endtask

    // Raise lines, wait for req, accept it with ack
    task automatic interrupt_round(input csr_pkg::ivec_t lines);
        logic [3:0]           code;
        logic [`CSR_XLEN-1:0] pc;
        int                   n;
        code = lines.mei ? 4'd11 : (lines.msi ? 4'd3 : 4'd7);  // Ext > sw > timer
        pc   = $urandom & ~32'h3;
        n    = 0;
        csr_op(3'b001, csr_pkg::CSR_MIE, 32'h888, 1'b0);
        csr_op(3'b001, csr_pkg::CSR_MSTATUS, 32'h8, 1'b0);
        irq <= lines;
        do begin
            @(posedge clk);
            n++;
        end while (!intr_req && n < REQ_TIMEOUT);
        if (!intr_req) begin
            errors++;
            $display("no interrupt request within %0d cycles", REQ_TIMEOUT);
        end
        csr_op(3'b010, csr_pkg::CSR_MIP, '0, 1'b1);
        intr_ack <= 1'b1;
        trap_pc  <= pc;
        @(posedge clk);
        sh_mepc   = pc;
        sh_mtval  = '0;
        sh_mcause = {1'b1, 27'h0, code};  // Interrupt view
        sh_mpie   = sh_mie_st;
        sh_mie_st = 1'b0;
        @(posedge clk);
        intr_ack  <= 1'b0;
        req_quiet = 1'b1;
        csr_op(3'b010, csr_pkg::CSR_MCAUSE, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MSTATUS, '0, 1'b1);
        irq <= '0;
        repeat (4) @(posedge clk);
        req_quiet = 1'b0;
    endtask

    task automatic report_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d failures", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin : main
        logic [2:0]           f;
        logic [11:0]          adr;
        logic [`CSR_XLEN-1:0] src;
        void'($urandom(32'h499aa755));
        fu       = '0;
        funct    = secv_pkg::FUNCT3_CSR_RW;
        ex_cause = secv_pkg::EX_CAUSE_INSTR_MISALIGNED;
        irq      = '0;
        rs1_zero = 1'b0;
        mret     = 1'b0;
        ex       = 1'b0;
        intr_ack = 1'b0;
        trap_pc  = '0;
        trap_adr = '0;
        exp_res  = '0;
        exp_err  = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        req_quiet = 1'b1;
        csr_op(3'b010, csr_pkg::CSR_MSTATUS, '0, 1'b1);  // Pure reads
        csr_op(3'b010, csr_pkg::CSR_MTVEC, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MISA, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MHARTID, '0, 1'b1);
        req_quiet = 1'b0;
        report_test("reset values");

        repeat (N_RAND) begin
            f   = funct_codes[$urandom_range(5)];
            adr = $urandom_range(1) ? csr_pkg::CSR_MSCRATCH : csr_pkg::CSR_MTVEC;
            src = $urandom;
            if (f[2]) src = src & 32'h1f;  // uimm field
            csr_op(f, adr, src, $urandom_range(3) == 0);
        end
        csr_op(3'b010, csr_pkg::CSR_MSCRATCH, '0, 1'b1);
        report_test("random read/write/set/clear");

        csr_op(3'b000, csr_pkg::CSR_MSCRATCH, $urandom, 1'b0);
        csr_op(3'b100, csr_pkg::CSR_MSCRATCH, $urandom, 1'b0);
        csr_op(3'b001, 12'h7C0, $urandom, 1'b0);            // Unknown
        csr_op(3'b001, csr_pkg::CSR_MHARTID, $urandom, 1'b0);
        csr_op(3'b010, csr_pkg::CSR_MISA, 32'hffff, 1'b0);
        csr_op(3'b010, csr_pkg::CSR_MSCRATCH, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MHARTID, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MISA, '0, 1'b1);
        report_test("illegal accesses");

        csr_op(3'b001, csr_pkg::CSR_MSTATUS, 32'h8, 1'b0);
        take_exception();
        csr_op(3'b010, csr_pkg::CSR_MEPC, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MCAUSE, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MTVAL, '0, 1'b1);
        csr_op(3'b010, csr_pkg::CSR_MSTATUS, '0, 1'b1);
        return_mret();
        csr_op(3'b010, csr_pkg::CSR_MSTATUS, '0, 1'b1);
        csr_op(3'b001, csr_pkg::CSR_MSTATUS, '0, 1'b0);
        report_test("exception and mret");

        interrupt_round(3'b011);  // Software over timer
        interrupt_round(3'b111);  // External wins
        report_test("interrupt handshake");

        req_quiet = 1'b1;
        csr_op(3'b001, csr_pkg::CSR_MIE, 32'h880, 1'b0);      // msi masked
        csr_op(3'b001, csr_pkg::CSR_MSTATUS, 32'h8, 1'b0);
        irq <= 3'b001;
        repeat (4) @(posedge clk);
        csr_op(3'b010, csr_pkg::CSR_MIP, '0, 1'b1);
        csr_op(3'b001, csr_pkg::CSR_MSTATUS, '0, 1'b0);       // Global off
        csr_op(3'b001, csr_pkg::CSR_MIE, 32'h888, 1'b0);
        irq <= 3'b111;
        repeat (4) @(posedge clk);
        csr_op(3'b010, csr_pkg::CSR_MIP, '0, 1'b1);
        irq <= '0;
        repeat (4) @(posedge clk);
        req_quiet = 1'b0;
        report_test("interrupt masking");

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", RUN_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/secv_pkg.sv
      - source/csr_pkg.sv
      - source/csr_intr.sv
      - source/csr_regs.sv
      - source/csr.sv
      - source/csr_unit_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/csr_tb.sv

// ==== tb.f ====
+incdir+include
source/secv_pkg.sv
source/csr_pkg.sv
source/csr_intr.sv
source/csr_regs.sv
source/csr.sv
source/csr_unit_top.sv
tb/csr_tb.sv
